//--- Makefile
# Verilator build and run for the byte-pipe register file.

VERILATOR  ?= verilator
TOP        := tb_bp_regs
RTL_TOP    := bp_regs_top
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		+incdir+common common/bp_pkg.sv hdl/bp_byte_fifo.sv \
		bp_reg_mem/bp_reg_mem.sv hdl/bp_regs_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bp_reg_mem/bp_reg_mem.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

// Byte-pipe command decoder and register memory.
// Each transaction returns exactly one response byte. A read gives the value
// at the address, a write gives the value the address held before the write.
module bp_reg_mem #(
  parameter int N_REG       = `BP_N_REG,      // implemented registers, 2 to 128.
  parameter int ZERO_UNIMPL = `BP_ZERO_UNIMPL // 1 returns zero above N_REG-1.
) (
  input  logic              i_clk,
  input  logic              i_arst_n,

  input  bp_pkg::bp_byte_t  i_bp_data,
  input  logic              i_bp_valid,
  output logic              o_bp_ready,

  output bp_pkg::bp_byte_t  o_bp_data,
  output logic              o_bp_valid,
  input  logic              i_bp_ready
);

  import bp_pkg::*;

  localparam int ADDR_W = $clog2(N_REG);                  // memory index width.
  localparam bp_addr_t ADDR_HI = bp_addr_t'(N_REG - 1);   // last implemented address.
  localparam logic CHECK_RANGE = (N_REG < 128) && (ZERO_UNIMPL != 0); // range test needed.

  bp_rx_state_e rx_state;       // command or write data expected.
  bp_addr_t     addr_q;         // target of the current write.
  logic         in_range_q;     // target is implemented.
  bp_byte_t     rsp_data;       // response byte.
  logic         rsp_valid;      // response waiting for the host side.

  bp_cmd_t      cmd;            // incoming byte seen as a command.
  logic         cmd_in_range;   // incoming address is implemented.
  logic         in_acc;         // byte accepted from the request side.
  logic         out_acc;        // response taken by the response side.
  logic         cmd_acc;        // command byte accepted.
  logic         wr_start;       // write command accepted.
  logic         data_acc;       // write data byte accepted.
  logic         rsp_load;       // transaction complete, load response.
  bp_addr_t     sel_addr;       // address the response is read from.
  logic         sel_in_range;   // range flag for that address.
  logic [ADDR_W-1:0] sel_idx;   // memory index of sel_addr.
  logic [ADDR_W-1:0] wr_idx;    // memory index of the write target.

  bp_byte_t     mem [N_REG];    // register array, no reset.

  assign cmd = bp_cmd_t'(i_bp_data);

  // address at or above N_REG is unimplemented when zeroing is on.
  assign cmd_in_range = !CHECK_RANGE || (cmd.addr <= ADDR_HI);

  // the response side controls all flow, one response slot per byte.
  assign o_bp_ready = i_bp_ready;

  assign in_acc   = i_bp_valid && o_bp_ready;
  assign out_acc  = rsp_valid && i_bp_ready;
  assign cmd_acc  = in_acc && (rx_state == BP_RX_CMD);
  assign wr_start = cmd_acc && cmd.wr;
  assign data_acc = in_acc && (rx_state == BP_RX_DATA);
  assign rsp_load = (cmd_acc && !cmd.wr) || data_acc;

  // a read uses the address in the command byte itself.
  // write data uses the address held since the command.
  assign sel_addr     = (rx_state == BP_RX_DATA) ? addr_q : cmd.addr;
  assign sel_in_range = (rx_state == BP_RX_DATA) ? in_range_q : cmd_in_range;
  assign sel_idx      = sel_addr[ADDR_W-1:0];
  assign wr_idx       = addr_q[ADDR_W-1:0];

  // receive state and response valid.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rx_state   <= BP_RX_CMD;
      rsp_valid  <= 1'b0;
      in_range_q <= 1'b0;
    end else begin
      if (wr_start) begin
        rx_state <= BP_RX_DATA;          // data byte comes next.
      end else if (data_acc) begin
        rx_state <= BP_RX_CMD;           // write done.
      end
      if (rsp_load) begin
        rsp_valid <= 1'b1;               // new response wins over a take.
      end else if (out_acc) begin
        rsp_valid <= 1'b0;
      end
      if (cmd_acc) begin
        in_range_q <= cmd_in_range;      // range flag taken at command time.
      end
    end
  end

  // target address and response byte.
  always_ff @(posedge i_clk) begin
    if (cmd_acc) begin
      addr_q <= cmd.addr;
    end
    if (rsp_load) begin
      rsp_data <= sel_in_range ? mem[sel_idx] : '0; // old value on a write.
    end
  end

  // write port, same edge as the response load so the old value is returned.
  always_ff @(posedge i_clk) begin
    if (data_acc && in_range_q) begin
      mem[wr_idx] <= i_bp_data;
    end
  end

  assign o_bp_data  = rsp_data;
  assign o_bp_valid = rsp_valid;

  // a response is held until the response side takes it.
  a_valid_held : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (o_bp_valid && !i_bp_ready) |=> o_bp_valid
  ) else $error("bp_reg_mem: response valid dropped before it was taken");

  // the held response must not change.
  a_data_stable : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (o_bp_valid && !i_bp_ready) |=> $stable(o_bp_data)
  ) else $error("bp_reg_mem: response data changed while stalled");

endmodule

//--- common/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// number of implemented registers.
// legal range is 2 to 128, addresses above this count are unimplemented.
`define BP_N_REG 64

// unimplemented addresses read as zero and drop writes when set.
// when clear, their read value is undefined.
`define BP_ZERO_UNIMPL 1

// entries in each of the request and response byte FIFOs.
// must be a power of two, at least 2.
`define BP_FIFO_DEPTH 4

// a command byte carries the write flag above a 7-bit address.
`define BP_ADDR_W 7

// width of every byte on the pipe.
`define BP_BYTE_W 8

`endif

//--- common/bp_pkg.sv
// Types for the byte-pipe register file.
package bp_pkg;

  `include "bp_defines.svh"

  // one byte on the pipe, used for commands, write data and responses.
  typedef logic [`BP_BYTE_W-1:0] bp_byte_t;

  // full address field of a command, 128 positions.
  typedef logic [`BP_ADDR_W-1:0] bp_addr_t;

  // view of a command byte.
  typedef struct packed {
    logic     wr;   // set for a write, clear for a read.
    bp_addr_t addr; // target register.
  } bp_cmd_t;

  // receive state of the register memory.
  typedef enum logic {
    BP_RX_CMD  = 1'b0, // next byte is a command.
    BP_RX_DATA = 1'b1  // next byte is the data byte of a write.
  } bp_rx_state_e;

endpackage

//--- hdl/bp_byte_fifo.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

// Synchronous byte FIFO with valid/ready on both sides.
// Circular buffer with read and write pointers and an occupancy count.
module bp_byte_fifo #(
  parameter int DEPTH = `BP_FIFO_DEPTH // power of two, at least 2.
) (
  input  logic              i_clk,
  input  logic              i_arst_n,

  input  bp_pkg::bp_byte_t  i_in_data,
  input  logic              i_in_valid,
  output logic              o_in_ready,

  output bp_pkg::bp_byte_t  o_out_data,
  output logic              o_out_valid,
  input  logic              i_out_ready
);

  import bp_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);      // pointer width, wraps at DEPTH.
  localparam int CNT_W = $clog2(DEPTH + 1);  // count holds 0 to DEPTH.

  bp_byte_t          mem [DEPTH];  // storage, no reset.
  logic [PTR_W-1:0]  wr_ptr;       // next slot to write.
  logic [PTR_W-1:0]  rd_ptr;       // oldest entry.
  logic [CNT_W-1:0]  count;        // entries held.

  logic push;    // byte accepted on the input side.
  logic pop;     // byte taken on the output side.
  logic full;    // no free slot.

  assign full        = (count == CNT_W'(DEPTH));
  assign o_in_ready  = !full;
  assign o_out_valid = (count != '0);
  assign o_out_data  = mem[rd_ptr];    // head of the queue.

  assign push = i_in_valid && o_in_ready;
  assign pop  = o_out_valid && i_out_ready;

  // pointers and count.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);   // wraps, DEPTH is a power of two.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;        // both or neither.
      endcase
    end
  end

  // storage write, a pushed byte shows at the output one clock later.
  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_in_data;
    end
  end

  // occupancy stays within the buffer.
  a_count_max : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    count <= CNT_W'(DEPTH)
  ) else $error("bp_byte_fifo: count above DEPTH");

  // an offered byte while full must not raise the count.
  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (i_in_valid && full) |=> (count == $past(count) - CNT_W'($past(pop)))
  ) else $error("bp_byte_fifo: push accepted while full");

endmodule

//--- hdl/bp_regs_top.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

// Byte-pipe register file top level.
// Request FIFO, register memory and response FIFO in a chain, so the host
// may keep a few bytes in flight.
module bp_regs_top (
  input  logic              i_clk,
  input  logic              i_arst_n,

  input  bp_pkg::bp_byte_t  i_bp_data,
  input  logic              i_bp_valid,
  output logic              o_bp_ready,

  output bp_pkg::bp_byte_t  o_bp_data,
  output logic              o_bp_valid,
  input  logic              i_bp_ready
);

  import bp_pkg::*;

  bp_byte_t req_data;   // request FIFO head.
  logic     req_valid;
  logic     req_ready;  // register memory takes a byte.
  bp_byte_t rsp_data;   // response from the register memory.
  logic     rsp_valid;
  logic     rsp_ready;  // response FIFO not full.

  bp_byte_fifo #(.DEPTH(`BP_FIFO_DEPTH)) u_req_fifo (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_in_data   (i_bp_data),
    .i_in_valid  (i_bp_valid),
    .o_in_ready  (o_bp_ready),
    .o_out_data  (req_data),
    .o_out_valid (req_valid),
    .i_out_ready (req_ready)
  );

  bp_reg_mem #(
    .N_REG       (`BP_N_REG),
    .ZERO_UNIMPL (`BP_ZERO_UNIMPL)
  ) u_reg_mem (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_bp_data  (req_data),
    .i_bp_valid (req_valid),
    .o_bp_ready (req_ready),
    .o_bp_data  (rsp_data),
    .o_bp_valid (rsp_valid),
    .i_bp_ready (rsp_ready)
  );

  bp_byte_fifo #(.DEPTH(`BP_FIFO_DEPTH)) u_rsp_fifo (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_in_data   (rsp_data),
    .i_in_valid  (rsp_valid),
    .o_in_ready  (rsp_ready),
    .o_out_data  (o_bp_data),
    .o_out_valid (o_bp_valid),
    .i_out_ready (i_bp_ready)
  );

endmodule

//--- verification/tb_bp_tasks.svh
`ifndef TB_BP_TASKS_SVH
`define TB_BP_TASKS_SVH

// tasks start and end on a falling edge.

task automatic stop_on_error();
  $display("Result: FAILED");
  $fatal(1, "simulation stopped at the first error.");
endtask

task automatic compare_byte(input string name, input bp_byte_t exp, input bp_byte_t act);
  if (act !== exp) begin
    $display("[FAIL] time %0t %s expected 0x%02h actual 0x%02h", $time, name, exp, act);
    stop_on_error();
  end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[FAIL] time %0t %s expected %b actual %b", $time, name, exp, act);
    stop_on_error();
  end
endtask

// command byte, write flag above the address.
function automatic bp_byte_t make_cmd(input logic wr, input bp_addr_t addr);
  bp_cmd_t cmd;
  cmd.wr   = wr;
  cmd.addr = addr;
  return bp_byte_t'(cmd);
endfunction

task automatic send_byte(input bp_byte_t b);
  int cycles;
  cycles     = 0;
  host_data  = b;
  host_valid = 1'b1;
  while (!dut_ready) begin
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("request byte 0x%02h was not accepted within %0d cycles", b, cycles);
      stop_on_error();
    end
    @(negedge clk);
    cycles++;
  end
  @(negedge clk);                  // transfer on the rising edge in between.
  host_valid = 1'b0;
endtask

task automatic recv_byte(output bp_byte_t b);
  int cycles;
  cycles     = 0;
  host_ready = 1'b1;
  while (!rsp_valid) begin
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("no response byte arrived within %0d cycles", cycles);
      stop_on_error();
    end
    @(negedge clk);
    cycles++;
  end
  b = rsp_data;                    // stable until the next rising edge.
  @(negedge clk);
  host_ready = 1'b0;
endtask

task automatic do_write(input bp_addr_t addr, input bp_byte_t data, output bp_byte_t old);
  send_byte(make_cmd(1'b1, addr));
  send_byte(data);
  recv_byte(old);                  // previous contents.
endtask

task automatic do_read(input bp_addr_t addr, output bp_byte_t val);
  send_byte(make_cmd(1'b0, addr));
  recv_byte(val);
endtask

`endif

//--- verification/tb_bp_regs.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module tb_bp_regs;

  import bp_pkg::*;

  localparam int TIMEOUT_CYCLES = 40;  // limit for any single handshake wait.
  localparam int STALL_LIMIT    = 64;  // read commands allowed before ready must drop.
  localparam int N_ADDR         = 128; // full 7-bit address space.
  localparam int N_RANDOM       = 40;  // random transactions per test.

  logic     clk;
  logic     arst_n;
  bp_byte_t host_data;   // request byte to the DUT.
  logic     host_valid;
  logic     dut_ready;   // request side can take a byte.
  bp_byte_t rsp_data;    // response byte from the DUT.
  logic     rsp_valid;
  logic     host_ready;  // host takes a response.

  bp_byte_t model [N_ADDR]; // expected register contents.
  int       seed;           // random state.

  bp_regs_top bp_regs_top_i (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_bp_data  (host_data),
    .i_bp_valid (host_valid),
    .o_bp_ready (dut_ready),
    .o_bp_data  (rsp_data),
    .o_bp_valid (rsp_valid),
    .i_bp_ready (host_ready)
  );

  `include "tb_bp_tasks.svh"

  // random address inside the implemented range.
  function automatic bp_addr_t rand_impl_addr();
    int unsigned r;
    r = $unsigned($random(seed));
    return bp_addr_t'(r % `BP_N_REG);
  endfunction

  // unimplemented addresses have a known value only with zeroing on.
  function automatic logic is_checked(input int a);
    return (a < `BP_N_REG) || (`BP_ZERO_UNIMPL != 0);
  endfunction

  // reset values, then clear the whole space and read it back.
  task automatic reset_and_clear();
    bp_byte_t val;
    compare_bit("o_bp_valid", 1'b0, rsp_valid);
    compare_bit("o_bp_ready", 1'b1, dut_ready);
    for (int a = 0; a < N_ADDR; a++) begin
      do_write(bp_addr_t'(a), 8'h00, val);
      if (a >= `BP_N_REG && `BP_ZERO_UNIMPL != 0) begin
        compare_byte("o_bp_data", 8'h00, val); // memory itself is not reset.
      end
      model[a] = 8'h00;
    end
    for (int a = 0; a < N_ADDR; a++) begin
      do_read(bp_addr_t'(a), val);
      if (is_checked(a)) begin
        compare_byte("o_bp_data", 8'h00, val);
      end
    end
  endtask

  // every write answers with the previous value.
  task automatic write_returns_old();
    bp_addr_t addr;
    bp_byte_t data;
    bp_byte_t val;
    repeat (N_RANDOM) begin
      addr = rand_impl_addr();
      data = bp_byte_t'($random(seed));
      do_write(addr, data, val);
      compare_byte("o_bp_data", model[addr], val);
      model[addr] = data;
    end
  endtask

  task automatic random_reads();
    bp_addr_t addr;
    bp_byte_t val;
    repeat (N_RANDOM) begin
      addr = rand_impl_addr();
      do_read(addr, val);
      compare_byte("o_bp_data", model[addr], val); // model unchanged.
    end
  endtask

  // writes above the implemented range are dropped.
  task automatic unimpl_ignored();
    bp_byte_t data;
    bp_byte_t val;
    if (`BP_ZERO_UNIMPL != 0) begin
      for (int a = `BP_N_REG; a < N_ADDR; a++) begin
        data = bp_byte_t'($random(seed));
        if (data == 8'h00) begin
          data = 8'h5a;                        // keep it nonzero.
        end
        do_write(bp_addr_t'(a), data, val);
        compare_byte("o_bp_data", 8'h00, val);
        do_read(bp_addr_t'(a), val);
        compare_byte("o_bp_data", 8'h00, val);
      end
      for (int a = 0; a < `BP_N_REG; a++) begin
        do_read(bp_addr_t'(a), val);
        compare_byte("o_bp_data", model[a], val); // no write reached the array.
      end
    end
  endtask

  // fill the whole chain with reads, then drain it in order.
  task automatic stall_and_drain();
    bp_addr_t pending [$];
    bp_addr_t addr;
    bp_byte_t val;
    int       sent;
    host_ready = 1'b0;
    sent = 0;
    while (dut_ready) begin
      if (sent >= STALL_LIMIT) begin
        $display("o_bp_ready did not drop after %0d read commands with i_bp_ready low",
                 sent);
        stop_on_error();
      end
      addr = rand_impl_addr();
      pending.push_back(addr);
      host_data  = make_cmd(1'b0, addr);
      host_valid = 1'b1;                       // taken at the next rising edge.
      @(negedge clk);
      sent++;
    end
    host_valid = 1'b0;
    $display("back-pressure reached after %0d read commands", sent);
    compare_bit("o_bp_valid", 1'b1, rsp_valid);
    while (pending.size() > 0) begin
      addr = pending.pop_front();
      recv_byte(val);
      compare_byte("o_bp_data", model[addr], val);
    end
    repeat (8) @(negedge clk);                 // a duplicate would show up here.
    compare_bit("o_bp_valid", 1'b0, rsp_valid);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    seed       = 32'hfe5b;
    arst_n     = 1'b0;
    host_data  = 8'h00;
    host_valid = 1'b0;
    host_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    reset_and_clear();
    write_returns_old();
    random_reads();
    unimpl_ignored();
    stall_and_drain();
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
+incdir+verification
common/bp_pkg.sv
hdl/bp_byte_fifo.sv
bp_reg_mem/bp_reg_mem.sv
hdl/bp_regs_top.sv
verification/tb_bp_regs.sv
